//--- logic/cache_rw_pkg.sv
package cache_rw_pkg;

  // cache geometry of 4 ways by 16 sets with 4 words per line
  localparam int addr_w         = 32;
  localparam int ways           = 4;
  localparam int way_w          = 2;
  localparam int sets           = 16;
  localparam int index_w        = 4;
  localparam int words_per_line = 4;
  localparam int word_w         = 2;
  localparam int bytes_w        = 4;
  localparam int offset_w       = $clog2(bytes_w);
  localparam int tag_w          = addr_w - index_w - word_w - offset_w;

  localparam logic [3:0] io_region = 4'hf;  // top nibble of every uncached IO address

  // controller FSM encodings
  localparam int          state_w     = 3;
  localparam logic [2:0]  st_idle     = 3'd0;
  localparam logic [2:0]  st_lookup   = 3'd1;
  localparam logic [2:0]  st_mem_cmd  = 3'd2;
  localparam logic [2:0]  st_mem_wait = 3'd3;
  localparam logic [2:0]  st_respond  = 3'd4;

  // one address word that is seen either whole or split into its cache fields
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [word_w-1:0]   word;
      logic [offset_w-1:0] offset;
    } f;
  } cache_addr_t;

endpackage

//--- logic/cache_array_if.sv
`timescale 1ns/1ps

interface cache_array_if;
  import cache_rw_pkg::*;

  // driven by the controller
  cache_addr_t        addr;     // address held for the request in flight
  logic               wr_en;
  logic [bytes_w-1:0] wr_be;
  logic [addr_w-1:0]  wr_data;
  logic               alloc;    // write goes to free_way and claims it

  // lookup results
  logic               hit;
  logic [way_w-1:0]   hit_way;
  logic               free;
  logic [way_w-1:0]   free_way;   // lowest numbered invalid way of the set
  logic [addr_w-1:0]  rd_data;
  logic [bytes_w-1:0] rd_mask;    // readable bytes of the hit word

  modport ctrl (
    output addr, wr_en, wr_be, wr_data, alloc,
    input  hit, hit_way, free, free_way, rd_data, rd_mask
  );

  modport tag (
    input  addr, alloc,
    output hit, hit_way, free, free_way
  );

  modport data (
    input  addr, wr_en, wr_be, wr_data, alloc, hit_way, free_way,
    output rd_data
  );

  modport readable (
    input  addr, wr_en, wr_be, alloc, hit_way, free_way,
    output rd_mask
  );

endinterface

//--- logic/cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array (
  input logic         clk,
  input logic         rest,
  cache_array_if.tag  arr
);
  import cache_rw_pkg::*;

  logic [sets-1:0][ways-1:0] valid_q;
  logic [tag_w-1:0]          tag_q [sets][ways];
  logic [index_w-1:0]        idx;

  assign idx = arr.addr.f.index;

  // walk the ways from the top down so the lowest numbered match wins
  always_comb begin
    arr.hit      = 1'b0;
    arr.hit_way  = '0;
    arr.free     = 1'b0;
    arr.free_way = '0;
    for (int w = ways - 1; w >= 0; w--) begin
      if (valid_q[idx][w] && (tag_q[idx][w] == arr.addr.f.tag)) begin
        arr.hit     = 1'b1;
        arr.hit_way = way_w'(w);
      end
      if (!valid_q[idx][w]) begin
        arr.free     = 1'b1;
        arr.free_way = way_w'(w);
      end
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      valid_q <= '0;
    end else if (arr.alloc) begin
      valid_q[idx][arr.free_way] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (arr.alloc) begin
      tag_q[idx][arr.free_way] <= arr.addr.f.tag;  // ways are never evicted once claimed
    end
  end

  // the controller only allocates a line that is really absent and has somewhere to go
  a_alloc_on_miss: assert property (@(posedge clk) disable iff (!rest)
    arr.alloc |-> !arr.hit && arr.free);

endmodule

//--- logic/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
  input logic          clk,
  cache_array_if.data  arr
);
  import cache_rw_pkg::*;

  logic [addr_w-1:0]  word_q [ways][sets][words_per_line];
  logic [way_w-1:0]   wr_way;
  logic [index_w-1:0] idx;
  logic [word_w-1:0]  wrd;

  assign idx    = arr.addr.f.index;
  assign wrd    = arr.addr.f.word;
  assign wr_way = arr.alloc ? arr.free_way : arr.hit_way;

  // the combinational read of the hit way is only meaningful while hit is high
  assign arr.rd_data = word_q[arr.hit_way][idx][wrd];

  always_ff @(posedge clk) begin
    if (arr.wr_en) begin
      for (int b = 0; b < bytes_w; b++) begin
        if (arr.wr_be[b]) begin
          word_q[wr_way][idx][wrd][8*b +: 8] <= arr.wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- logic/cache_readable_array.sv
`timescale 1ns/1ps

module cache_readable_array (
  input logic              clk,
  input logic              rest,
  cache_array_if.readable  arr
);
  import cache_rw_pkg::*;

  // one bit per byte that is set once the byte has been written into the cache
  logic [bytes_w-1:0] mask_q [ways][sets][words_per_line];
  logic [way_w-1:0]   wr_way;
  logic [index_w-1:0] idx;
  logic [word_w-1:0]  wrd;

  assign idx    = arr.addr.f.index;
  assign wrd    = arr.addr.f.word;
  assign wr_way = arr.alloc ? arr.free_way : arr.hit_way;

  assign arr.rd_mask = mask_q[arr.hit_way][idx][wrd];

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      for (int w = 0; w < ways; w++) begin
        for (int s = 0; s < sets; s++) begin
          for (int k = 0; k < words_per_line; k++) begin
            mask_q[w][s][k] <= '0;
          end
        end
      end
    end else if (arr.wr_en) begin
      if (arr.alloc) begin
        for (int k = 0; k < words_per_line; k++) begin
          mask_q[wr_way][idx][k] <= '0;  // a fresh line holds nothing readable
        end
        mask_q[wr_way][idx][wrd] <= arr.wr_be;  // overrides the clear for the written word
      end else begin
        mask_q[wr_way][idx][wrd] <= mask_q[wr_way][idx][wrd] | arr.wr_be;
      end
    end
  end

endmodule

//--- logic/cache_rw_ctrl.sv
`timescale 1ns/1ps

module cache_rw_ctrl (
  input  logic                               clk,
  input  logic                               rest,
  input  logic                               req_valid,
  output logic                               req_ready,
  input  logic                               req_write,
  input  logic [cache_rw_pkg::addr_w-1:0]    req_addr,
  input  logic [cache_rw_pkg::bytes_w-1:0]   req_be,
  input  logic [cache_rw_pkg::addr_w-1:0]    req_wdata,
  output logic                               rsp_valid,
  input  logic                               rsp_ready,
  output logic [cache_rw_pkg::addr_w-1:0]    rsp_rdata,
  output logic                               mem_cmd_valid,
  input  logic                               mem_cmd_ready,
  output logic                               mem_cmd_write,
  output logic [cache_rw_pkg::addr_w-1:0]    mem_cmd_addr,
  output logic [cache_rw_pkg::bytes_w-1:0]   mem_cmd_be,
  output logic [cache_rw_pkg::addr_w-1:0]    mem_cmd_wdata,
  input  logic                               mem_rsp_valid,
  input  logic [cache_rw_pkg::addr_w-1:0]    mem_rsp_rdata,
  cache_array_if.ctrl                        arr
);
  import cache_rw_pkg::*;

  logic [state_w-1:0] state;
  cache_addr_t        req_addr_q;
  logic               req_write_q;
  logic [bytes_w-1:0] req_be_q;
  logic [addr_w-1:0]  req_wdata_q;
  logic [addr_w-1:0]  mem_rdata_q;  // memory word, zero when the cache served the read
  logic               is_io;
  logic               readable_ok;
  logic               forward;
  logic [bytes_w-1:0] cache_mask;
  logic [addr_w-1:0]  merged;

  assign req_ready = (state == st_idle);

  assign is_io       = (req_addr_q.raw[addr_w-1 -: 4] == io_region);
  assign readable_ok = ((arr.rd_mask & req_be_q) == req_be_q);

  // anything the cache cannot serve on its own goes to memory
  assign forward = is_io ||
                   (!req_write_q && (!arr.hit || !readable_ok)) ||
                   (req_write_q && !arr.hit && !arr.free);

  assign arr.addr    = req_addr_q;
  assign arr.wr_en   = (state == st_lookup) && req_write_q && !forward;
  assign arr.alloc   = arr.wr_en && !arr.hit;  // write miss claims the free way
  assign arr.wr_be   = req_be_q;
  assign arr.wr_data = req_wdata_q;

  assign mem_cmd_write = req_write_q;
  assign mem_cmd_addr  = req_addr_q.raw;
  assign mem_cmd_be    = req_be_q;
  assign mem_cmd_wdata = req_wdata_q;

  // cached readable bytes take priority over whatever memory returned
  assign cache_mask = (arr.hit && !is_io) ? arr.rd_mask : '0;

  always_comb begin
    for (int b = 0; b < bytes_w; b++) begin
      merged[8*b +: 8] = cache_mask[b] ? arr.rd_data[8*b +: 8] : mem_rdata_q[8*b +: 8];
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state         <= st_idle;
      rsp_valid     <= 1'b0;
      mem_cmd_valid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (req_valid) state <= st_lookup;
        end
        st_lookup: begin
          state <= forward ? st_mem_cmd : st_respond;  // cache writes land on this edge
        end
        st_mem_cmd: begin
          if (!mem_cmd_valid) begin
            mem_cmd_valid <= 1'b1;
          end else if (mem_cmd_ready) begin
            mem_cmd_valid <= 1'b0;
            state         <= st_mem_wait;
          end
        end
        st_mem_wait: begin
          if (mem_rsp_valid) state <= st_respond;  // writes are acknowledged too
        end
        st_respond: begin
          if (!rsp_valid) begin
            rsp_valid <= 1'b1;
          end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_addr_q.raw <= req_addr;
      req_write_q    <= req_write;
      req_be_q       <= req_be;
      req_wdata_q    <= req_wdata;
      mem_rdata_q    <= '0;
    end
    if (state == st_mem_wait && mem_rsp_valid) mem_rdata_q <= mem_rsp_rdata;
    if (state == st_respond && !rsp_valid) begin
      rsp_rdata <= req_write_q ? '0 : merged;
    end
  end

  // the requester and the memory may stall and nothing moves under them until they accept
  a_rsp_hold: assert property (@(posedge clk) disable iff (!rest)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

  a_mem_cmd_hold: assert property (@(posedge clk) disable iff (!rest)
    mem_cmd_valid && !mem_cmd_ready |=> mem_cmd_valid && $stable(mem_cmd_addr));

endmodule

//--- logic/cache_rw_top.sv
`timescale 1ns/1ps

module cache_rw_top (
  input  logic                               clk,
  input  logic                               rest,
  input  logic                               req_valid,
  output logic                               req_ready,
  input  logic                               req_write,
  input  logic [cache_rw_pkg::addr_w-1:0]    req_addr,
  input  logic [cache_rw_pkg::bytes_w-1:0]   req_be,
  input  logic [cache_rw_pkg::addr_w-1:0]    req_wdata,
  output logic                               rsp_valid,
  input  logic                               rsp_ready,
  output logic [cache_rw_pkg::addr_w-1:0]    rsp_rdata,
  output logic                               mem_cmd_valid,
  input  logic                               mem_cmd_ready,
  output logic                               mem_cmd_write,
  output logic [cache_rw_pkg::addr_w-1:0]    mem_cmd_addr,
  output logic [cache_rw_pkg::bytes_w-1:0]   mem_cmd_be,
  output logic [cache_rw_pkg::addr_w-1:0]    mem_cmd_wdata,
  input  logic                               mem_rsp_valid,
  input  logic [cache_rw_pkg::addr_w-1:0]    mem_rsp_rdata
);

  cache_array_if arr_if ();  // controller to array signals

  cache_rw_ctrl u_ctrl (
    .clk           (clk),
    .rest          (rest),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_be        (req_be),
    .req_wdata     (req_wdata),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_rdata     (rsp_rdata),
    .mem_cmd_valid (mem_cmd_valid),
    .mem_cmd_ready (mem_cmd_ready),
    .mem_cmd_write (mem_cmd_write),
    .mem_cmd_addr  (mem_cmd_addr),
    .mem_cmd_be    (mem_cmd_be),
    .mem_cmd_wdata (mem_cmd_wdata),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_rdata (mem_rsp_rdata),
    .arr           (arr_if.ctrl)
  );

  cache_tag_array u_tag (
    .clk  (clk),
    .rest (rest),
    .arr  (arr_if.tag)
  );

  cache_data_array u_data (
    .clk (clk),
    .arr (arr_if.data)
  );

  cache_readable_array u_readable (
    .clk  (clk),
    .rest (rest),
    .arr  (arr_if.readable)
  );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rest
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    rest = 1'b0;
    repeat (2) @(posedge clk);
    #10 rest = 1'b1;  // released away from the clock edge
  end

endmodule

//--- verif/cache_rw_tb.sv
`timescale 1ns/1ps

module cache_rw_tb;
  import cache_rw_pkg::*;

  localparam int n_requests   = 217;  // every request the six tests issue
  localparam int cycle_budget = 40;

  logic               clk;
  logic               rest;
  logic               req_valid;
  logic               req_ready;
  logic               req_write;
  logic [addr_w-1:0]  req_addr;
  logic [bytes_w-1:0] req_be;
  logic [addr_w-1:0]  req_wdata;
  logic               rsp_valid;
  logic               rsp_ready = 1'b0;
  logic [addr_w-1:0]  rsp_rdata;
  logic               mem_cmd_valid;
  logic               mem_cmd_ready = 1'b0;
  logic               mem_cmd_write;
  logic [addr_w-1:0]  mem_cmd_addr;
  logic [bytes_w-1:0] mem_cmd_be;
  logic [addr_w-1:0]  mem_cmd_wdata;
  logic               mem_rsp_valid = 1'b0;
  logic [addr_w-1:0]  mem_rsp_rdata = '0;

  logic [addr_w-1:0] mem_store [logic [29:0]];  // words the memory model has been written with
  logic [addr_w-1:0] shadow [logic [29:0]];     // the requester's view of every write
  string             exp_name [$];
  logic [addr_w-1:0] exp_data [$];
  logic [addr_w-1:0] last_cmd_addr = '0;
  logic              last_cmd_write = 1'b0;
  int cycle = 0;
  int mem_cmds = 0;
  int rsp_count = 0;
  int checks = 0;
  int errors = 0;
  int failed_tests = 0;

  tb_clock u_clock (.clk(clk), .rest(rest));

  cache_rw_top uut (.*);

  function automatic logic [addr_w-1:0] pattern(input logic [addr_w-1:0] addr);
    return {2'b00, addr[31:2]} ^ 32'h5a5a_0000;  // word address folded with a marker
  endfunction

  function automatic logic [addr_w-1:0] merge_bytes(input logic [addr_w-1:0] old_word,
      input logic [addr_w-1:0] new_word, input logic [bytes_w-1:0] be);
    logic [addr_w-1:0] word;
    word = old_word;
    for (int b = 0; b < bytes_w; b++) begin
      if (be[b]) word[8*b +: 8] = new_word[8*b +: 8];
    end
    return word;
  endfunction

  // a read returns the latest written bytes over the initial pattern
  function automatic logic [addr_w-1:0] expected_read(input logic [addr_w-1:0] addr);
    if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
    return pattern(addr);
  endfunction

  function automatic logic [addr_w-1:0] memory_word(input logic [addr_w-1:0] addr);
    if (mem_store.exists(addr[31:2])) return mem_store[addr[31:2]];
    return pattern(addr);
  endfunction

  task automatic check_equal(input string name, input logic [addr_w-1:0] expected,
      input logic [addr_w-1:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // issues one request and returns once its response has transferred
  task automatic run_request(input string name, input logic write, input logic [addr_w-1:0] addr,
      input logic [bytes_w-1:0] be, input logic [addr_w-1:0] wdata, output int latency,
      output int cmds);
    int cmds_before;
    int rsps_before;
    int accept_edge;
    cmds_before = mem_cmds;
    rsps_before = rsp_count;
    exp_name.push_back(name);
    if (write) begin
      shadow[addr[31:2]] = merge_bytes(expected_read(addr), wdata, be);
      exp_data.push_back('0);  // write responses carry zero
    end else begin
      exp_data.push_back(expected_read(addr));
    end
    @(posedge clk);
    #10;
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_be    = be;
    req_wdata = wdata;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    accept_edge = cycle + 1;
    @(posedge clk);
    #10;
    req_valid = 1'b0;
    @(negedge clk);
    while (!rsp_valid) @(negedge clk);
    latency = cycle - accept_edge;
    wait (rsp_count != rsps_before);
    cmds = mem_cmds - cmds_before;
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d mismatches", name, errors - errors_before);
    end
  endtask

  always @(posedge clk) cycle++;

  always @(posedge clk) begin
    #10;
    rsp_ready     = ($urandom % 4) != 0;
    mem_cmd_ready = ($urandom % 3) != 0;
  end

  // memory model answers every command after 0 to 3 idle cycles
  always begin
    int unsigned delay;
    logic [addr_w-1:0] data;
    @(negedge clk);
    if (mem_cmd_valid && mem_cmd_ready) begin
      mem_cmds++;
      last_cmd_addr  = mem_cmd_addr;
      last_cmd_write = mem_cmd_write;
      data = mem_cmd_write ? '0 : memory_word(mem_cmd_addr);
      if (mem_cmd_write) begin
        mem_store[mem_cmd_addr[31:2]] = merge_bytes(memory_word(mem_cmd_addr), mem_cmd_wdata,
                                                    mem_cmd_be);
      end
      delay = $urandom % 4;
      @(posedge clk);
      repeat (delay) @(posedge clk);
      #10;
      mem_rsp_valid = 1'b1;
      mem_rsp_rdata = data;
      @(posedge clk);
      #10;
      mem_rsp_valid = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (rsp_valid && rsp_ready) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("a response arrived while no request was outstanding");
      end else begin
        check_equal(exp_name.pop_front(), exp_data.pop_front(), rsp_rdata);
      end
      rsp_count++;
    end
  end

  initial begin
    repeat (n_requests * cycle_budget) @(posedge clk);
    $display("watchdog expired after %0d cycles, a handshake never completed",
             n_requests * cycle_budget);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int lat;
    int cmds;
    int errs_before;
    logic [addr_w-1:0] addr;
    cache_addr_t rnd_addr;
    void'($urandom(32'hc1d7_f4e1));
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_be    = '0;
    req_wdata = '0;
    wait (rest === 1'b1);

    errs_before = errors;
    run_request("alloc write", 1'b1, 32'h0000_1010, 4'hf, 32'h1234_5678, lat, cmds);
    check_equal("alloc write memory commands", 0, cmds);
    run_request("alloc read", 1'b0, 32'h0000_1010, 4'hf, '0, lat, cmds);
    check_equal("alloc read latency", 2, lat);
    check_equal("alloc read memory commands", 0, cmds);
    report_test("write allocate", errs_before);

    errs_before = errors;
    run_request("partial write", 1'b1, 32'h0000_2024, 4'b0101, 32'haabb_ccdd, lat, cmds);
    run_request("partial read", 1'b0, 32'h0000_2024, 4'hf, '0, lat, cmds);
    check_equal("partial read memory commands", 1, cmds);
    report_test("partial merge", errs_before);

    errs_before = errors;
    run_request("cold read", 1'b0, 32'h0000_3038, 4'hf, '0, lat, cmds);
    check_equal("cold read memory commands", 1, cmds);
    report_test("cold read", errs_before);

    errs_before = errors;
    run_request("io write", 1'b1, 32'hf000_0040, 4'hf, 32'hcafe_f00d, lat, cmds);
    check_equal("io write memory commands", 1, cmds);
    check_equal("io write address", 32'hf000_0040, last_cmd_addr);
    check_equal("io write command", 1, 32'(last_cmd_write));
    run_request("io read", 1'b0, 32'hf000_0040, 4'hf, '0, lat, cmds);
    check_equal("io read memory commands", 1, cmds);
    report_test("io region", errs_before);

    errs_before = errors;
    for (int t = 1; t <= 5; t++) begin
      addr = (t << 8) | 32'h5c;  // five tags that all map to set 5
      run_request($sformatf("set fill write %0d", t), 1'b1, addr, 4'hf, 32'h5e70_0000 + t,
                  lat, cmds);
      check_equal($sformatf("set fill memory commands %0d", t), (t == 5) ? 1 : 0, cmds);
    end
    for (int t = 1; t <= 5; t++) begin
      run_request($sformatf("set fill read %0d", t), 1'b0, (t << 8) | 32'h5c, 4'hf, '0,
                  lat, cmds);
    end
    report_test("full set", errs_before);

    errs_before = errors;
    for (int i = 0; i < 200; i++) begin
      rnd_addr.raw     = '0;
      rnd_addr.f.tag   = tag_w'($urandom % 6);  // six tags compete for four ways
      rnd_addr.f.index = index_w'(8 + $urandom % 2);
      rnd_addr.f.word  = word_w'($urandom % 4);
      addr = rnd_addr.raw;
      if ($urandom % 2 == 0) begin
        run_request("random write", 1'b1, addr, 4'($urandom % 15 + 1), $urandom, lat, cmds);
      end else begin
        run_request("random read", 1'b0, addr, 4'hf, '0, lat, cmds);
      end
    end
    report_test("random traffic", errs_before);

    $display("tests 6, failed %0d, checks %0d, mismatches %0d", failed_tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- cache_rw.f
logic/cache_rw_pkg.sv
logic/cache_array_if.sv
logic/cache_tag_array.sv
logic/cache_data_array.sv
logic/cache_readable_array.sv
logic/cache_rw_ctrl.sv
logic/cache_rw_top.sv
verif/tb_clock.sv
verif/cache_rw_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module cache_rw_tb -f cache_rw.f -o sim_cache_rw
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_cache_rw > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '** FAIL **' "$log"; then
  exit 1
fi
exit 0
